//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;

    // first fetch address
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    typedef enum logic [2:0] {
        IF,
        ID,
        EXE,
        MEM,
        WB
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI   // passes src2
    } alu_op_t;

    // how the next pc is chosen in ID
    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } br_kind_t;

endpackage

//--- src/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
    import cpu_pkg::*;

    alu_op_t         alu_op;
    br_kind_t        br_kind;
    logic            src1_is_pc;
    logic            src2_is_imm;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] br_offs;   // already shifted by 2
    logic            is_load;
    logic            is_store;
    logic            gr_we;
    logic [4:0]      dest;

    modport dec (
        output alu_op, br_kind, src1_is_pc, src2_is_imm, imm, br_offs,
               is_load, is_store, gr_we, dest
    );

    modport seq (
        input  alu_op, br_kind, src1_is_pc, src2_is_imm, imm, br_offs,
               is_load, is_store, gr_we, dest
    );

endinterface

//--- src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0] inst,
    decode_if.dec       ctl,
    output logic [4:0]  rf_raddr1,
    output logic [4:0]  rf_raddr2
);
    import cpu_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [XLEN-1:0] si12_ext;
    logic [XLEN-1:0] offs16;
    logic [XLEN-1:0] offs26;
    logic        long_offs;   // b and bl use si26
    logic        reg_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];

    assign si12_ext = {{20{inst[21]}}, inst[21:10]};   // ui5 sits in the low bits too
    assign offs16   = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26   = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        ctl.alu_op      = ALU_ADD;
        ctl.br_kind     = BR_NONE;
        ctl.src1_is_pc  = 1'b0;
        ctl.src2_is_imm = 1'b0;
        ctl.imm         = si12_ext;
        ctl.is_load     = 1'b0;
        ctl.is_store    = 1'b0;
        ctl.gr_we       = 1'b0;
        ctl.dest        = rd;
        long_offs       = 1'b0;
        reg_is_rd       = 1'b0;

        if (op_31_26 == 6'h00 && op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
            ctl.gr_we = 1'b1;
            case (op_19_15)
                5'h00: ctl.alu_op = ALU_ADD;
                5'h02: ctl.alu_op = ALU_SUB;
                5'h04: ctl.alu_op = ALU_SLT;
                5'h05: ctl.alu_op = ALU_SLTU;
                5'h08: ctl.alu_op = ALU_NOR;
                5'h09: ctl.alu_op = ALU_AND;
                5'h0a: ctl.alu_op = ALU_OR;
                5'h0b: ctl.alu_op = ALU_XOR;
                default: ctl.gr_we = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
            ctl.gr_we       = 1'b1;
            ctl.src2_is_imm = 1'b1;
            case (op_19_15)
                5'h01: ctl.alu_op = ALU_SLL;
                5'h09: ctl.alu_op = ALU_SRL;
                5'h11: ctl.alu_op = ALU_SRA;
                default: ctl.gr_we = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'ha) begin   // addi.w
            ctl.gr_we       = 1'b1;
            ctl.src2_is_imm = 1'b1;
        end else if (op_31_26 == 6'h05 && !inst[25]) begin          // lu12i.w
            ctl.alu_op      = ALU_LUI;
            ctl.gr_we       = 1'b1;
            ctl.src2_is_imm = 1'b1;
            ctl.imm         = {inst[24:5], 12'b0};
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h2) begin   // ld.w
            ctl.is_load     = 1'b1;
            ctl.gr_we       = 1'b1;
            ctl.src2_is_imm = 1'b1;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h6) begin   // st.w
            ctl.is_store    = 1'b1;
            ctl.src2_is_imm = 1'b1;
            reg_is_rd       = 1'b1;
        end else begin
            case (op_31_26)
                6'h13: begin   // jirl links pc+4
                    ctl.br_kind     = BR_JIRL;
                    ctl.gr_we       = 1'b1;
                    ctl.src1_is_pc  = 1'b1;
                    ctl.src2_is_imm = 1'b1;
                    ctl.imm         = 32'd4;
                end
                6'h14: begin
                    ctl.br_kind = BR_B;
                    long_offs   = 1'b1;
                end
                6'h15: begin
                    ctl.br_kind     = BR_BL;
                    ctl.gr_we       = 1'b1;
                    ctl.src1_is_pc  = 1'b1;
                    ctl.src2_is_imm = 1'b1;
                    ctl.imm         = 32'd4;
                    ctl.dest        = 5'd1;
                    long_offs       = 1'b1;
                end
                6'h16: begin
                    ctl.br_kind = BR_BEQ;
                    reg_is_rd   = 1'b1;
                end
                6'h17: begin
                    ctl.br_kind = BR_BNE;
                    reg_is_rd   = 1'b1;
                end
                default: ;   // unknown encodings run as a no-op
            endcase
        end
    end

    assign ctl.br_offs = long_offs ? offs26 : offs16;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = reg_is_rd ? rd : rk;

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                     clk,
    input  logic [4:0]               raddr1,
    input  logic [4:0]               raddr2,
    input  logic                     we,
    input  logic [4:0]               waddr,
    input  logic [cpu_pkg::XLEN-1:0] wdata,
    output logic [cpu_pkg::XLEN-1:0] rdata1,
    output logic [cpu_pkg::XLEN-1:0] rdata2
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t         alu_op,
    input  logic [cpu_pkg::XLEN-1:0] alu_src1,
    input  logic [cpu_pkg::XLEN-1:0] alu_src2,
    output logic [cpu_pkg::XLEN-1:0] alu_result
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_src1 + alu_src2;
            ALU_SUB:  alu_result = alu_src1 - alu_src2;
            ALU_SLT:  alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            ALU_SLTU: alu_result = {31'b0, alu_src1 < alu_src2};
            ALU_AND:  alu_result = alu_src1 & alu_src2;
            ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            ALU_OR:   alu_result = alu_src1 | alu_src2;
            ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            ALU_SLL:  alu_result = alu_src1 << shamt;
            ALU_SRL:  alu_result = alu_src1 >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            ALU_LUI:  alu_result = alu_src2;   // upper immediate built by decoder
            default:  alu_result = '0;
        endcase
    end

endmodule

//--- src/multicycle_seq.sv
`timescale 1ns/1ps

module multicycle_seq (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              inst_sram_rdata,
    input  logic [cpu_pkg::XLEN-1:0] data_sram_rdata,
    input  logic [cpu_pkg::XLEN-1:0] rf_rdata1,
    input  logic [cpu_pkg::XLEN-1:0] rf_rdata2,
    input  logic [cpu_pkg::XLEN-1:0] alu_result,
    decode_if.seq                    dec,
    output logic [31:0]              inst,
    output logic [cpu_pkg::XLEN-1:0] inst_sram_addr,
    output cpu_pkg::alu_op_t         alu_op,
    output logic [cpu_pkg::XLEN-1:0] alu_src1,
    output logic [cpu_pkg::XLEN-1:0] alu_src2,
    output logic                     data_sram_we,
    output logic [cpu_pkg::XLEN-1:0] data_sram_addr,
    output logic [cpu_pkg::XLEN-1:0] data_sram_wdata,
    output logic                     rf_we,
    output logic [4:0]               rf_waddr,
    output logic [cpu_pkg::XLEN-1:0] rf_wdata,
    output logic [cpu_pkg::XLEN-1:0] debug_wb_pc
);
    import cpu_pkg::*;

    state_t          state;
    state_t          state_next;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] npc_q;
    logic [XLEN-1:0] rj_val;
    logic [XLEN-1:0] rkd_val;
    logic [XLEN-1:0] alu_res_q;
    logic [XLEN-1:0] load_q;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] next_pc;

    always_comb begin
        case (state)
            IF:  state_next = ID;
            ID:  begin
                // plain branches finish here
                if (dec.br_kind == BR_B || dec.br_kind == BR_BEQ || dec.br_kind == BR_BNE)
                    state_next = IF;
                else
                    state_next = EXE;
            end
            EXE: state_next = (dec.is_load || dec.is_store) ? MEM : WB;
            MEM: state_next = dec.is_load ? WB : IF;
            WB:  state_next = IF;
            default: state_next = IF;
        endcase
    end

    // resolved in ID from the live register reads
    always_comb begin
        case (dec.br_kind)
            BR_B, BR_BL, BR_JIRL: br_taken = 1'b1;
            BR_BEQ:  br_taken = (rf_rdata1 == rf_rdata2);
            BR_BNE:  br_taken = (rf_rdata1 != rf_rdata2);
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target = (dec.br_kind == BR_JIRL) ? rf_rdata1 + dec.br_offs : pc + dec.br_offs;
    assign next_pc   = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (state != IF && state_next == IF) begin   // last state of the instruction
                pc <= (state == ID) ? next_pc : npc_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IF) inst <= inst_sram_rdata;
        if (state == ID) begin
            rj_val  <= rf_rdata1;
            rkd_val <= rf_rdata2;
            npc_q   <= next_pc;
        end
        if (state == EXE) alu_res_q <= alu_result;
        if (state == MEM) load_q <= data_sram_rdata;
    end

    assign inst_sram_addr = pc;

    assign alu_op   = dec.alu_op;
    assign alu_src1 = dec.src1_is_pc ? pc : rj_val;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_val;

    assign data_sram_we    = (state == MEM) && dec.is_store;
    assign data_sram_addr  = alu_res_q;
    assign data_sram_wdata = rkd_val;   // rd for st.w

    assign rf_we       = (state == WB) && dec.gr_we;
    assign rf_waddr    = dec.dest;
    assign rf_wdata    = dec.is_load ? load_q : alu_res_q;
    assign debug_wb_pc = pc;

    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> state == MEM && $past(state) == EXE)
        else $error("store strobe outside MEM");

    a_write_in_wb: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> state == WB && ($past(state) == EXE || $past(state) == MEM))
        else $error("register write outside WB");

    a_if_then_id: assert property (@(posedge clk) disable iff (reset)
        state == IF |=> state == ID)
        else $error("IF not followed by ID");

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] inst_sram_rdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] inst_sram_addr,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    decode_if dec_bus ();

    logic [31:0]     inst;
    logic [4:0]      rf_raddr1;
    logic [4:0]      rf_raddr2;
    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    alu_op_t         alu_op;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;

    multicycle_seq u_seq (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram_rdata (data_sram_rdata),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .alu_result      (alu_result),
        .dec             (dec_bus.seq),
        .inst            (inst),
        .inst_sram_addr  (inst_sram_addr),
        .alu_op          (alu_op),
        .alu_src1        (alu_src1),
        .alu_src2        (alu_src2),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .debug_wb_pc     (debug_wb_pc)
    );

    inst_decoder u_decoder (
        .inst      (inst),
        .ctl       (dec_bus.dec),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    // trace mirrors the register write port
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- bench/tb_program.svh
// program words placed from RESET_PC upward
localparam int PROG_LEN = 32;

localparam logic [31:0] PROGRAM [PROG_LEN] = '{
    32'h02bf_ec04, 32'h0280_1c05, 32'h0010_1486, 32'h0011_10a7,   // addi x2, add.w, sub.w
    32'h0012_1488, 32'h0012_9489, 32'h0014_00aa, 32'h0014_948b,   // slt, sltu, nor, and
    32'h0015_148c, 32'h0015_948d, 32'h0040_90ae, 32'h0044_908f,   // or, xor, slli.w, srli.w
    32'h0048_8490, 32'h1424_68b1, 32'h0280_2400, 32'h0010_1412,   // srai.w, lu12i.w, r0 write/read
    32'h0284_0013, 32'h2980_2271, 32'h2880_2274, 32'h5800_08b2,   // base, st.w, ld.w, beq taken
    32'h0280_0415, 32'h5c00_08b2, 32'h5c00_0885, 32'h0280_0815,   // bne falls through, bne taken
    32'h5000_0800, 32'h0280_0c15, 32'h5400_0800, 32'h0280_1015,   // b, bl
    32'h4c00_0c36, 32'h0280_1415, 32'h029f_fc17, 32'h5000_0000    // jirl r22 r1 12, b to self
};

// one entry per writeback or store in program order
typedef struct packed {
    logic        is_store;
    logic [31:0] a;      // pc of a writeback, address of a store
    logic [4:0]  num;
    logic [31:0] data;
} trace_event_t;

localparam int N_EVENTS = 22;

localparam trace_event_t EVENTS [N_EVENTS] = '{
    '{1'b0, 32'h1c00_0000, 5'd4,  32'hffff_fffb},
    '{1'b0, 32'h1c00_0004, 5'd5,  32'h0000_0007},
    '{1'b0, 32'h1c00_0008, 5'd6,  32'h0000_0002},
    '{1'b0, 32'h1c00_000c, 5'd7,  32'h0000_000c},
    '{1'b0, 32'h1c00_0010, 5'd8,  32'h0000_0001},   // -5 < 7 signed
    '{1'b0, 32'h1c00_0014, 5'd9,  32'h0000_0000},   // but not unsigned
    '{1'b0, 32'h1c00_0018, 5'd10, 32'hffff_fff8},
    '{1'b0, 32'h1c00_001c, 5'd11, 32'h0000_0003},
    '{1'b0, 32'h1c00_0020, 5'd12, 32'hffff_ffff},
    '{1'b0, 32'h1c00_0024, 5'd13, 32'hffff_fffc},
    '{1'b0, 32'h1c00_0028, 5'd14, 32'h0000_0070},
    '{1'b0, 32'h1c00_002c, 5'd15, 32'h0fff_ffff},
    '{1'b0, 32'h1c00_0030, 5'd16, 32'hffff_fffd},
    '{1'b0, 32'h1c00_0034, 5'd17, 32'h1234_5000},
    '{1'b0, 32'h1c00_0038, 5'd0,  32'h0000_0009},   // traced yet r0 keeps zero
    '{1'b0, 32'h1c00_003c, 5'd18, 32'h0000_0007},
    '{1'b0, 32'h1c00_0040, 5'd19, 32'h0000_0100},
    '{1'b1, 32'h0000_0108, 5'd0,  32'h1234_5000},
    '{1'b0, 32'h1c00_0048, 5'd20, 32'h1234_5000},
    '{1'b0, 32'h1c00_0068, 5'd1,  32'h1c00_006c},   // bl link
    '{1'b0, 32'h1c00_0070, 5'd22, 32'h1c00_0074},   // jirl link
    '{1'b0, 32'h1c00_0078, 5'd23, 32'h0000_07ff}    // lands on the jirl target
};

//--- bench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    `include "tb_program.svh"

    // at most 5 cycles per instruction
    localparam int TIMEOUT_CYCLES = PROG_LEN * 5 + 50;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] inst_sram_addr;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] inst_mem [PROG_LEN];
    logic [31:0] data_mem [256];
    logic [31:0] inst_offs;
    int          errors;
    int          cycles;
    int          ev_idx;

    cpu_top u_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_rdata   (data_sram_rdata),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #10 clk = ~clk;

    // both memories answer in the same cycle
    assign inst_offs       = inst_sram_addr - RESET_PC;
    assign inst_sram_rdata = (inst_offs < PROG_LEN * 4) ? inst_mem[inst_offs[6:2]] : 32'h0;
    assign data_sram_rdata = data_mem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_we) begin
            data_mem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic compare_event(input trace_event_t ev);
        if (ev.is_store && !data_sram_we) begin
            $display("error at %0t: event %0d should be a store, a writeback came", $time, ev_idx);
            errors++;
        end else if (!ev.is_store && !debug_wb_rf_we) begin
            $display("error at %0t: event %0d should be a writeback, a store came", $time, ev_idx);
            errors++;
        end else if (ev.is_store) begin
            if (data_sram_addr !== ev.a) report_mismatch("data_sram_addr", ev.a, data_sram_addr);
            if (data_sram_wdata !== ev.data) begin
                report_mismatch("data_sram_wdata", ev.data, data_sram_wdata);
            end
        end else begin
            if (debug_wb_pc !== ev.a) report_mismatch("debug_wb_pc", ev.a, debug_wb_pc);
            if (debug_wb_rf_wnum !== ev.num) begin
                report_mismatch("debug_wb_rf_wnum", {27'b0, ev.num}, {27'b0, debug_wb_rf_wnum});
            end
            if (debug_wb_rf_wdata !== ev.data) begin
                report_mismatch("debug_wb_rf_wdata", ev.data, debug_wb_rf_wdata);
            end
        end
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        errors = 0;
        cycles = 0;
        ev_idx = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            inst_mem[i] = PROGRAM[i];
        end
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = 32'hd0d0_0000 | (i << 2);   // word address as fill
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        if (inst_sram_addr !== RESET_PC) report_mismatch("inst_sram_addr", RESET_PC, inst_sram_addr);
        if (data_sram_we !== 1'b0) report_mismatch("data_sram_we", 32'd0, {31'b0, data_sram_we});
        if (debug_wb_rf_we !== 1'b0) begin
            report_mismatch("debug_wb_rf_we", 32'd0, {31'b0, debug_wb_rf_we});
        end

        while (ev_idx < N_EVENTS && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            if (debug_wb_rf_we || data_sram_we) begin
                compare_event(EVENTS[ev_idx]);
                ev_idx++;
            end
        end

        if (ev_idx < N_EVENTS) begin
            $display("timeout after %0d cycles, only %0d of %0d events seen",
                     cycles, ev_idx, N_EVENTS);
            errors++;
        end else begin
            // core should now spin in the b-to-self loop
            repeat (20) begin
                @(posedge clk);
                if (debug_wb_rf_we || data_sram_we) begin
                    $display("error at %0t: writeback or store after the last expected event",
                             $time);
                    errors++;
                end
            end
        end

        $display("errors: %0d, events checked: %0d of %0d", errors, ev_idx, N_EVENTS);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+bench
src/cpu_pkg.sv
src/decode_if.sv
src/inst_decoder.sv
src/regfile.sv
src/alu.sv
src/multicycle_seq.sv
src/cpu_top.sv
bench/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --assert -f list.f --top-module tb_cpu -o tb_cpu \
    && ./obj_dir/tb_cpu > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test passed" sim.log && exit 0 || exit 1
